// File: hdl/miner_pkg.sv
// ====================
// Shared types and constants for the nonce search accelerator
// PID codes and views, reply packet and lane result layout
// Import inside module bodies, scoped names in port lists
// ====================

package miner_pkg;

	// Host packet identifiers, low nibble of the PID byte
	typedef enum logic [3:0] {
		PID_ACK   = 4'h2,
		PID_DATA0 = 4'h3,
		PID_NACK  = 4'hA
	} pid_code_e;

	// Check nibble is the complement of the code
	typedef struct packed {
		logic [3:0] check;
		pid_code_e  code;
	} pid_fields_t;

	// Same PID byte seen raw or split into nibbles
	typedef union packed {
		logic [7:0]  raw;
		pid_fields_t f;
	} pid_u;

	typedef struct packed {
		pid_u        pid;
		logic [15:0] data;
	} tx_pkt_t;

	typedef struct packed {
		logic        hit;
		logic [31:0] nonce;
	} lane_res_t;

	// Added into every hash round
	localparam logic [31:0] ROUND_KEY = 32'h9E37_79B9;

endpackage

// File: hdl/nonce_dispatch.sv
// ====================
// Batch dispatcher for the hash lanes
// Latches the block header, keeps the base nonce of the batch
// and fans out base + i to lane i with a one-cycle start pulse
// ====================

module nonce_dispatch #(
	parameter int LANES = 4
) (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic [31:0]            header,
	input  logic                   new_block,
	input  logic                   begin_hash,
	input  logic                   increment,
	input  logic                   quit_hash,
	output logic                   start,
	output logic [31:0]            block_header,
	output logic [LANES-1:0][31:0] lane_nonce
);

	logic [31:0] base;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			base  <= '0;
			start <= 1'b0;
		end else begin
			// Never start a batch while the lanes are being cleared
			start <= begin_hash & ~quit_hash;
			if (new_block) begin
				base <= '0;
			end else if (increment) begin
				base <= base + 32'(LANES);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (new_block) begin
			block_header <= header;
		end
	end

	// Consecutive nonces across the lanes
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			lane_nonce[i] = base + 32'(i);
		end
	end

endmodule

// File: hdl/hash_lane.sv
// ====================
// One hash lane
// Mixes header and nonce with an add-rotate-xor round for ROUNDS
// cycles after start, then holds done and the difficulty result
// ====================

module hash_lane #(
	parameter int ROUNDS = 8
) (
	input  logic                 clk,
	input  logic                 n_rst,
	input  logic                 start,
	input  logic                 abort,
	input  logic [31:0]          header,
	input  logic [31:0]          nonce,
	input  logic [4:0]           difficulty,
	output logic                 done,
	output miner_pkg::lane_res_t res
);
	import miner_pkg::*;

	localparam int CW = $clog2(ROUNDS + 1);

	logic [31:0]   state;
	logic [31:0]   next_mix;
	logic [31:0]   zero_mask;
	logic [31:0]   nonce_q;
	logic [CW-1:0] cnt;
	logic          run;
	logic          hit_q;

	function automatic logic [31:0] mix(input logic [31:0] s);
		mix = {s[26:0], s[31:27]} + (s ^ ROUND_KEY);
	endfunction

	assign next_mix  = mix(state);
	// Top difficulty bits must be zero
	assign zero_mask = ~(32'hFFFF_FFFF >> difficulty);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			run   <= 1'b0;
			done  <= 1'b0;
			hit_q <= 1'b0;
			cnt   <= '0;
		end else if (abort) begin
			run   <= 1'b0;
			done  <= 1'b0;
			hit_q <= 1'b0;
		end else if (start) begin
			// First round is folded into the load
			run   <= 1'b1;
			done  <= 1'b0;
			hit_q <= 1'b0;
			cnt   <= CW'(1);
		end else if (run) begin
			cnt <= cnt + CW'(1);
			if (cnt == CW'(ROUNDS - 1)) begin
				run   <= 1'b0;
				done  <= 1'b1;
				hit_q <= (next_mix & zero_mask) == 32'd0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			state   <= mix(header ^ nonce);
			nonce_q <= nonce;
		end else if (run) begin
			state <= next_mix;
		end
	end

	assign res = '{hit: hit_q, nonce: nonce_q};

endmodule

// File: hdl/result_collect.sv
// ====================
// Lane result collector
// Pulses hash_done once when every lane has finished and reports
// the lowest-index hit, held until the next batch completes
// ====================

module result_collect #(
	parameter int LANES = 4
) (
	input  logic                             clk,
	input  logic                             n_rst,
	input  logic                             abort,
	input  logic [LANES-1:0]                 lane_done,
	input  miner_pkg::lane_res_t [LANES-1:0] lane_res,
	output logic                             hash_done,
	output logic                             valid_hash_flag,
	output logic [31:0]                      win_nonce
);
	import miner_pkg::*;

	logic      all_done;
	logic      all_q;
	lane_res_t pick;

	assign all_done = &lane_done;

	// Walk down so the lowest lane, the smallest nonce, wins
	always_comb begin
		pick = '0;
		for (int i = LANES - 1; i >= 0; i--) begin
			if (lane_res[i].hit) begin
				pick = lane_res[i];
			end
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			all_q           <= 1'b0;
			hash_done       <= 1'b0;
			valid_hash_flag <= 1'b0;
		end else if (abort) begin
			all_q           <= 1'b0;
			hash_done       <= 1'b0;
			valid_hash_flag <= 1'b0;
		end else begin
			all_q     <= all_done;
			hash_done <= all_done & ~all_q;
			if (all_done && !all_q) begin
				valid_hash_flag <= pick.hit;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (all_done && !all_q) begin
			win_nonce <= pick.nonce;
		end
	end

endmodule

// File: hdl/main_controller.sv
// ====================
// Main search controller
// Steps the nonce search batch by batch, answers host polls
// with DATA0, ACK and NACK packets from a registered reply
// ====================

module main_controller (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               new_block,
	input  logic               host_ready,
	input  logic               transmit_ack,
	input  logic               transmit_nack,
	input  logic               hash_done,
	input  logic               valid_hash_flag,
	input  logic [31:0]        win_nonce,
	output logic               begin_hash,
	output logic               increment,
	output logic               quit_hash,
	output logic               busy,
	output miner_pkg::tx_pkt_t tx_pkt,
	output logic               tx_valid
);
	import miner_pkg::*;

	typedef enum logic [3:0] {
		IDLE,
		BEGIN_HASH,
		HASH_DONE,
		TRANSMIT_START,
		TRANSMIT_EMPTY,
		TRANSMIT_ACK,
		TRANSMIT_NACK,
		VALID_HASH_WAIT
	} state_e;

	state_e      state;
	state_e      next_state;
	logic        done_pend;
	logic        done_seen;
	logic        take_done;
	logic        pkt_load;
	pid_code_e   code;
	pid_u        pid_v;
	logic [15:0] data_v;

	// A batch result that arrives behind a host request is kept
	assign done_seen = hash_done | done_pend;

	always_comb begin
		next_state = state;
		begin_hash = 1'b0;
		increment  = 1'b0;
		quit_hash  = 1'b0;
		take_done  = 1'b0;
		case (state)
			IDLE: begin
				if (new_block) begin
					next_state = BEGIN_HASH;
					quit_hash  = busy;
				end else if (host_ready) begin
					next_state = TRANSMIT_EMPTY;
				end else if (transmit_ack) begin
					next_state = TRANSMIT_ACK;
				end else if (transmit_nack) begin
					next_state = TRANSMIT_NACK;
				end else if (done_seen) begin
					take_done  = 1'b1;
					next_state = valid_hash_flag ? VALID_HASH_WAIT : HASH_DONE;
				end
			end
			BEGIN_HASH: begin
				begin_hash = 1'b1;
				next_state = IDLE;
			end
			HASH_DONE: begin
				increment  = 1'b1;
				next_state = BEGIN_HASH;
			end
			VALID_HASH_WAIT: begin
				if (host_ready) begin
					next_state = TRANSMIT_START;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// Reply contents for the transmit states
	always_comb begin
		code     = PID_DATA0;
		data_v   = '0;
		pkt_load = 1'b1;
		case (state)
			TRANSMIT_START: data_v = win_nonce[15:0];
			TRANSMIT_EMPTY: data_v = '0;
			TRANSMIT_ACK:   code   = PID_ACK;
			TRANSMIT_NACK:  code   = PID_NACK;
			default:        pkt_load = 1'b0;
		endcase
		pid_v.f.code  = code;
		pid_v.f.check = ~code;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state     <= IDLE;
			busy      <= 1'b0;
			done_pend <= 1'b0;
			tx_valid  <= 1'b0;
		end else begin
			state    <= next_state;
			tx_valid <= pkt_load;
			if (state == IDLE && new_block) begin
				busy <= 1'b1;
			end else if (take_done && valid_hash_flag) begin
				busy <= 1'b0;
			end
			if ((state == IDLE && new_block) || take_done) begin
				done_pend <= 1'b0;
			end else if (hash_done) begin
				done_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pkt_load) begin
			tx_pkt <= '{pid: pid_v, data: data_v};
		end
	end

endmodule

// File: hdl/miner_top.sv
// ====================
// Nonce search accelerator top level
// Dispatcher, LANES hash lanes, collector and controller
// Host loads header and difficulty, then pulses new_block
// ====================

module miner_top #(
	parameter int LANES  = 4,
	parameter int ROUNDS = 8
) (
	input  logic               clk,
	input  logic               n_rst,
	input  logic [31:0]        header,
	input  logic [4:0]         difficulty,
	input  logic               new_block,
	input  logic               host_ready,
	input  logic               transmit_ack,
	input  logic               transmit_nack,
	output miner_pkg::tx_pkt_t tx_pkt,
	output logic               tx_valid,
	output logic               busy
);
	import miner_pkg::*;

	logic                   begin_hash;
	logic                   increment;
	logic                   quit_hash;
	logic                   start;
	logic [31:0]            block_header;
	logic [LANES-1:0][31:0] lane_nonce;
	logic [LANES-1:0]       lane_done;
	lane_res_t [LANES-1:0]  lane_res;
	logic                   hash_done;
	logic                   valid_hash_flag;
	logic [31:0]            win_nonce;

	nonce_dispatch #(
		.LANES(LANES)
	) nonce_dispatch_i (
		.clk          (clk),
		.n_rst        (n_rst),
		.header       (header),
		.new_block    (new_block),
		.begin_hash   (begin_hash),
		.increment    (increment),
		.quit_hash    (quit_hash),
		.start        (start),
		.block_header (block_header),
		.lane_nonce   (lane_nonce)
	);

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		hash_lane #(
			.ROUNDS(ROUNDS)
		) hash_lane_i (
			.clk        (clk),
			.n_rst      (n_rst),
			.start      (start),
			.abort      (quit_hash),
			.header     (block_header),
			.nonce      (lane_nonce[i]),
			.difficulty (difficulty),
			.done       (lane_done[i]),
			.res        (lane_res[i])
		);
	end

	result_collect #(
		.LANES(LANES)
	) result_collect_i (
		.clk             (clk),
		.n_rst           (n_rst),
		.abort           (quit_hash),
		.lane_done       (lane_done),
		.lane_res        (lane_res),
		.hash_done       (hash_done),
		.valid_hash_flag (valid_hash_flag),
		.win_nonce       (win_nonce)
	);

	main_controller main_controller_i (
		.clk             (clk),
		.n_rst           (n_rst),
		.new_block       (new_block),
		.host_ready      (host_ready),
		.transmit_ack    (transmit_ack),
		.transmit_nack   (transmit_nack),
		.hash_done       (hash_done),
		.valid_hash_flag (valid_hash_flag),
		.win_nonce       (win_nonce),
		.begin_hash      (begin_hash),
		.increment       (increment),
		.quit_hash       (quit_hash),
		.busy            (busy),
		.tx_pkt          (tx_pkt),
		.tx_valid        (tx_valid)
	);

endmodule

// File: bench/miner_chk.sv
// ====================
// Protocol checks on the main controller
// Bound into every main_controller instance
// ====================

module miner_chk (
	input logic               clk,
	input logic               n_rst,
	input logic               tx_valid,
	input logic               begin_hash,
	input logic               increment,
	input miner_pkg::tx_pkt_t tx_pkt
);
	import miner_pkg::*;

	int assert_fails = 0;

	// One packet per request, never back to back
	a_valid_single: assert property (@(posedge clk) disable iff (!n_rst)
		tx_valid |=> !tx_valid)
		else begin
			assert_fails++;
			$error("tx_valid high in two consecutive cycles");
		end

	a_begin_vs_incr: assert property (@(posedge clk) disable iff (!n_rst)
		!(begin_hash && increment))
		else begin
			assert_fails++;
			$error("begin_hash and increment high together");
		end

	a_pid_check: assert property (@(posedge clk) disable iff (!n_rst)
		tx_valid |-> (tx_pkt.pid.f.check == ~tx_pkt.pid.f.code))
		else begin
			assert_fails++;
			$error("PID check nibble is not the complement of the code");
		end

endmodule

bind main_controller miner_chk miner_chk_i (
	.clk        (clk),
	.n_rst      (n_rst),
	.tx_valid   (tx_valid),
	.begin_hash (begin_hash),
	.increment  (increment),
	.tx_pkt     (tx_pkt)
);

// File: bench/miner_tb.sv
// ====================
// Testbench for the nonce search accelerator
// Random headers and difficulties from a fixed seed, a software
// hash model for the first winning nonce, reply packet checks
// ====================

module miner_tb;
	import miner_pkg::*;

	localparam int LANES    = 4;
	localparam int ROUNDS   = 8;
	localparam int NUM_HDR  = 20;
	localparam int MAX_DIFF = 7;
	// Mean search length at the top difficulty with a wide margin
	localparam int WATCHDOG_CYCLES =
		NUM_HDR * (2 ** MAX_DIFF / LANES) * (ROUNDS + 4) * 16 + 1000;

	localparam int REQ_READY = 0;
	localparam int REQ_ACK   = 1;
	localparam int REQ_NACK  = 2;

	logic        clk;
	logic        n_rst;
	logic [31:0] header;
	logic [4:0]  difficulty;
	logic        new_block;
	logic        host_ready;
	logic        transmit_ack;
	logic        transmit_nack;
	tx_pkt_t     tx_pkt;
	logic        tx_valid;
	logic        busy;

	int          seed;

	miner_top #(
		.LANES  (LANES),
		.ROUNDS (ROUNDS)
	) miner_top_i (
		.clk           (clk),
		.n_rst         (n_rst),
		.header        (header),
		.difficulty    (difficulty),
		.new_block     (new_block),
		.host_ready    (host_ready),
		.transmit_ack  (transmit_ack),
		.transmit_nack (transmit_nack),
		.tx_pkt        (tx_pkt),
		.tx_valid      (tx_valid),
		.busy          (busy)
	);

	always #4 clk = ~clk;

	// Reference hash with a rotate by 5 and a keyed xor add per round
	function automatic logic [31:0] hash_word(input logic [31:0] hdr, input logic [31:0] nonce);
		logic [31:0] s;
		s = hdr ^ nonce;
		for (int r = 0; r < ROUNDS; r++) begin
			s = ((s << 5) | (s >> 27)) + (s ^ ROUND_KEY);
		end
		return s;
	endfunction

	function automatic logic meets_difficulty(input logic [31:0] h, input logic [4:0] diff);
		return (h >> (32 - int'(diff))) == 32'd0;
	endfunction

	function automatic logic [31:0] first_winner(input logic [31:0] hdr, input logic [4:0] diff);
		logic [31:0] n;
		n = 32'd0;
		while (!meets_difficulty(hash_word(hdr, n), diff) && n < 32'h0010_0000) begin
			n = n + 32'd1;
		end
		return n;
	endfunction

	function automatic tx_pkt_t make_pkt(input logic [7:0] pid_raw, input logic [15:0] data);
		tx_pkt_t p;
		p.pid.raw = pid_raw;
		p.data    = data;
		return p;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_pkt(input string name, input tx_pkt_t exp, input tx_pkt_t act);
		if (act !== exp) begin
			fail_run($sformatf(
				"[ERROR] %s: expected pid %h data %h, actual pid %h (check %h code %h) data %h",
				name, exp.pid.raw, exp.data, act.pid.raw, act.pid.f.check, act.pid.f.code,
				act.data));
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("[ERROR] %s: expected busy %0b, actual busy %0b", name, exp, act));
		end
	endtask

	// One request pulse and its reply two clocks later
	task automatic poll_reply(input string name, input int kind, input tx_pkt_t exp);
		case (kind)
			REQ_ACK:  transmit_ack = 1'b1;
			REQ_NACK: transmit_nack = 1'b1;
			default:  host_ready = 1'b1;
		endcase
		@(negedge clk);
		host_ready    = 1'b0;
		transmit_ack  = 1'b0;
		transmit_nack = 1'b0;
		if (tx_valid) begin
			fail_run($sformatf("%s: reply packet came one cycle early", name));
		end
		@(negedge clk);
		if (!tx_valid) begin
			fail_run($sformatf("%s: no reply packet two cycles after the request", name));
		end
		check_pkt(name, exp, tx_pkt);
	endtask

	task automatic load_block(input logic [31:0] hdr, input logic [4:0] diff);
		header     = hdr;
		difficulty = diff;
		new_block  = 1'b1;
		@(negedge clk);
		new_block = 1'b0;
		check_busy("busy after new_block", 1'b1, busy);
	endtask

	task automatic wait_search_end(input string name, input int limit);
		int n;
		n = 0;
		while (busy && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			fail_run($sformatf("%s: busy still high after %0d cycles", name, limit));
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_run("watchdog expired before the test sequence finished");
	end

	initial begin
		logic [31:0] hdr;
		logic [4:0]  diff;
		logic [31:0] exp_nonce;
		int          rnd;
		int          limit;

		seed          = 32'h0842_c5a0;
		clk           = 1'b0;
		n_rst         = 1'b0;
		header        = '0;
		difficulty    = '0;
		new_block     = 1'b0;
		host_ready    = 1'b0;
		transmit_ack  = 1'b0;
		transmit_nack = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		n_rst = 1'b1;

		// Quiet outputs after reset
		repeat (4) begin
			@(negedge clk);
			if (tx_valid) begin
				fail_run("tx_valid went high after reset with no request");
			end
			check_busy("busy after reset", 1'b0, busy);
		end

		poll_reply("ack after reset", REQ_ACK, make_pkt(8'hD2, 16'h0000));
		poll_reply("nack after reset", REQ_NACK, make_pkt(8'h5A, 16'h0000));

		for (int h = 0; h < NUM_HDR; h++) begin
			hdr       = $random(seed);
			rnd       = $random(seed);
			diff      = 5'(4 + (rnd & 3));
			exp_nonce = first_winner(hdr, diff);
			load_block(hdr, diff);
			repeat (2) @(negedge clk);

			// Fresh header on the clock where the first batch would finish
			if ((h % 4) == 1) begin
				repeat (ROUNDS - 2) @(negedge clk);
				hdr       = $random(seed);
				exp_nonce = first_winner(hdr, diff);
				load_block(hdr, diff);
				repeat (2) @(negedge clk);
			end

			poll_reply("empty poll during search", REQ_READY, make_pkt(8'hC3, 16'h0000));
			check_busy("busy after empty poll", 1'b1, busy);

			limit = (int'(exp_nonce) / LANES + 1) * (ROUNDS + 4) + 16;
			wait_search_end("search", limit);
			poll_reply("winning nonce", REQ_READY, make_pkt(8'hC3, exp_nonce[15:0]));
			check_busy("busy after winner reply", 1'b0, busy);

			rnd = $random(seed);
			if ((rnd & 3) == 0 || (rnd & 3) == 2) begin
				poll_reply("ack in idle", REQ_ACK, make_pkt(8'hD2, 16'h0000));
			end
			if ((rnd & 3) == 1 || (rnd & 3) == 2) begin
				poll_reply("nack in idle", REQ_NACK, make_pkt(8'h5A, 16'h0000));
			end
			@(negedge clk);
		end

		if (miner_top_i.main_controller_i.miner_chk_i.assert_fails != 0) begin
			fail_run("protocol checker reported assertion failures");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// File: tb.f
hdl/miner_pkg.sv
hdl/nonce_dispatch.sv
hdl/hash_lane.sv
hdl/result_collect.sv
hdl/main_controller.sv
hdl/miner_top.sv
bench/miner_chk.sv
bench/miner_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module miner_tb -f tb.f -o miner_sim

./obj_dir/miner_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
